/* hw/fetch_pkg.sv */
package fetch_pkg;

	// ======================================================================
	// Fetch geometry
	// ======================================================================

	// Two 4-byte slots per 8-byte block, slot picked by pc[2]
	localparam int FETCH_WIDTH = 2;
	// Return stack pointer width
	localparam int RAS_PTR_W = 3;
	// Target table index width, taken from pc[5:2]
	localparam int LPHT_ADDR_WIDTH = 4;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [RAS_PTR_W-1:0] ras_ptr_t;
	typedef logic [LPHT_ADDR_WIDTH-1:0] lpht_idx_t;

	// Slot kind as seen by predictor and pre-decoder
	typedef enum logic [1:0] {
		BR_NONE,
		BR_BRANCH,
		BR_CALL,
		BR_RET
	} br_type_e;

	// ======================================================================
	// Structures passed between blocks
	// ======================================================================

	// Prediction for one fetch block
	typedef struct packed {
		logic     taken;
		logic     br_idx;
		addr_t    npc;
		ras_ptr_t ras_ptr;
	} br_info_t;

	// One fetch queue entry
	typedef struct packed {
		addr_t                     pc;
		logic [FETCH_WIDTH-1:0]    valid;
		inst_t [FETCH_WIDTH-1:0]   inst;
		br_type_e [FETCH_WIDTH-1:0] br_type;
		br_info_t                  br_info;
	} fetch_pkt_t;

	// Redirect back to the predictor
	typedef struct packed {
		addr_t     pc;
		addr_t     target;
		ras_ptr_t  ras_ptr;
		lpht_idx_t lpht_idx;
	} redirect_t;

endpackage

/* hw/branch_predictor.sv */
module branch_predictor #(
	parameter fetch_pkg::addr_t RESET_PC = 32'h0000_1000
) (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  logic                                almost_full_i,
	input  logic                                redirect_valid_i,
	input  fetch_pkg::redirect_t                redirect_i,
	input  logic                                upd_valid_i,
	input  fetch_pkg::addr_t                    upd_pc_i,
	input  fetch_pkg::addr_t                    upd_target_i,
	input  fetch_pkg::br_type_e                 upd_type_i,
	output logic                                fetch_req_o,
	output fetch_pkg::addr_t                    fetch_pc_o,
	output logic                                inflight_valid_o,
	output logic [fetch_pkg::FETCH_WIDTH-1:0]   inflight_slot_valid_o,
	output fetch_pkg::br_info_t                 inflight_info_o,
	output fetch_pkg::addr_t                    inflight_pc_o
);

	// Tag is everything above the index and the byte offset
	localparam int TAG_W = 32 - fetch_pkg::LPHT_ADDR_WIDTH - 2;
	localparam int LPHT_DEPTH = 2 ** fetch_pkg::LPHT_ADDR_WIDTH;

	typedef logic [TAG_W-1:0] tag_t;

	typedef struct packed {
		tag_t                tag;
		fetch_pkg::addr_t    target;
		fetch_pkg::br_type_e kind;
	} lpht_entry_t;

	// ======================================================================
	// State
	// ======================================================================

	fetch_pkg::addr_t    pc_q;
	fetch_pkg::ras_ptr_t ras_q;
	logic                req_en_q;
	logic [LPHT_DEPTH-1:0] lpht_valid_q;
	lpht_entry_t         lpht_q [LPHT_DEPTH];

	// In-flight request, waiting one cycle for memory
	logic                inflight_valid_q;
	fetch_pkg::addr_t    inflight_pc_q;
	logic [fetch_pkg::FETCH_WIDTH-1:0] inflight_slot_q;
	fetch_pkg::br_info_t inflight_info_q;

	// Lookup results
	fetch_pkg::lpht_idx_t [fetch_pkg::FETCH_WIDTH-1:0] slot_idx;
	logic [fetch_pkg::FETCH_WIDTH-1:0] slot_en;
	logic [fetch_pkg::FETCH_WIDTH-1:0] hit;
	logic [fetch_pkg::FETCH_WIDTH-1:0] slot_valid;
	fetch_pkg::br_info_t pred_info;
	fetch_pkg::br_type_e pred_kind;
	fetch_pkg::ras_ptr_t ras_next;
	fetch_pkg::addr_t    blk_pc;
	fetch_pkg::lpht_idx_t upd_idx;

	assign blk_pc = {pc_q[31:3], 3'b000};
	assign upd_idx = upd_pc_i[fetch_pkg::LPHT_ADDR_WIDTH+1:2];

	// No request in reset, under back-pressure or while redirecting
	assign fetch_req_o = req_en_q & ~almost_full_i & ~redirect_valid_i;
	assign fetch_pc_o = blk_pc;

	// ======================================================================
	// Table lookup for both slots
	// ======================================================================

	always_comb begin
		// Slot 0 is skipped when the PC enters at slot 1
		slot_en[0] = ~pc_q[2];
		slot_en[1] = 1'b1;
		for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
			slot_idx[i] = {pc_q[fetch_pkg::LPHT_ADDR_WIDTH+1:3], i[0]};
			hit[i] = slot_en[i] && lpht_valid_q[slot_idx[i]] &&
				(lpht_q[slot_idx[i]].tag == pc_q[31:fetch_pkg::LPHT_ADDR_WIDTH+2]);
		end

		// Fall-through by default
		pred_info.taken = 1'b0;
		pred_info.br_idx = 1'b0;
		pred_info.npc = blk_pc + 32'd8;
		pred_info.ras_ptr = ras_q;
		pred_kind = fetch_pkg::BR_NONE;
		// Walk down so the oldest hit wins
		for (int i = fetch_pkg::FETCH_WIDTH - 1; i >= 0; i--) begin
			if (hit[i]) begin
				pred_info.taken = 1'b1;
				pred_info.br_idx = i[0];
				pred_info.npc = lpht_q[slot_idx[i]].target;
				pred_kind = lpht_q[slot_idx[i]].kind;
			end
		end

		// Younger slot dies behind a taken slot 0
		slot_valid[0] = slot_en[0];
		slot_valid[1] = ~(pred_info.taken && !pred_info.br_idx);
	end

	// Return stack pointer movement
	always_comb begin
		case (pred_kind)
			fetch_pkg::BR_CALL: ras_next = ras_q + fetch_pkg::ras_ptr_t'(1);
			fetch_pkg::BR_RET:  ras_next = ras_q - fetch_pkg::ras_ptr_t'(1);
			default:            ras_next = ras_q;
		endcase
	end

	// ======================================================================
	// Control registers
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q <= RESET_PC;
			ras_q <= '0;
			req_en_q <= 1'b0;
			inflight_valid_q <= 1'b0;
			lpht_valid_q <= '0;
		end else begin
			req_en_q <= 1'b1;
			inflight_valid_q <= fetch_req_o;
			if (redirect_valid_i) begin
				pc_q <= redirect_i.target;
				ras_q <= redirect_i.ras_ptr;
			end else if (fetch_req_o) begin
				pc_q <= pred_info.npc;
				ras_q <= ras_next;
			end
			if (upd_valid_i) begin
				lpht_valid_q[upd_idx] <= 1'b1;
			end
			// Invalidation comes last, so it beats training
			if (redirect_valid_i) begin
				lpht_valid_q[redirect_i.lpht_idx] <= 1'b0;
			end
		end
	end

	// Table payload and in-flight payload
	always_ff @(posedge clk) begin
		if (upd_valid_i) begin
			lpht_q[upd_idx].tag <= upd_pc_i[31:fetch_pkg::LPHT_ADDR_WIDTH+2];
			lpht_q[upd_idx].target <= upd_target_i;
			lpht_q[upd_idx].kind <= upd_type_i;
		end
		if (fetch_req_o) begin
			inflight_pc_q <= blk_pc;
			inflight_slot_q <= slot_valid;
			inflight_info_q <= pred_info;
		end
	end

	// Push is dropped in a redirect cycle
	assign inflight_valid_o = inflight_valid_q & ~redirect_valid_i;
	assign inflight_slot_valid_o = inflight_slot_q;
	assign inflight_info_o = inflight_info_q;
	assign inflight_pc_o = inflight_pc_q;

endmodule

/* hw/pre_decoder.sv */
module pre_decoder (
	input  fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0]    inst_i,
	output fetch_pkg::br_type_e [fetch_pkg::FETCH_WIDTH-1:0] br_type_o
);

	// Major opcodes, bits 6:0
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	// Link register x1
	localparam logic [4:0] REG_RA     = 5'd1;
	localparam logic [4:0] REG_ZERO   = 5'd0;

	logic [fetch_pkg::FETCH_WIDTH-1:0][6:0] opcode;
	logic [fetch_pkg::FETCH_WIDTH-1:0][4:0] rd;
	logic [fetch_pkg::FETCH_WIDTH-1:0][4:0] rs1;

	always_comb begin
		for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
			opcode[i] = inst_i[i][6:0];
			rd[i] = inst_i[i][11:7];
			rs1[i] = inst_i[i][19:15];

			// Plain word unless proven otherwise
			br_type_o[i] = fetch_pkg::BR_NONE;
			if (opcode[i] == OPC_BRANCH) begin
				br_type_o[i] = fetch_pkg::BR_BRANCH;
			end else if (opcode[i] == OPC_JAL && rd[i] == REG_RA) begin
				// Jump and link into ra
				br_type_o[i] = fetch_pkg::BR_CALL;
			end else if (opcode[i] == OPC_JALR && rs1[i] == REG_RA &&
				rd[i] == REG_ZERO) begin
				// Jump through ra, no link
				br_type_o[i] = fetch_pkg::BR_RET;
			end
		end
	end

endmodule

/* hw/fetch_queue.sv */
module fetch_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  push_i,
	input  fetch_pkg::fetch_pkt_t push_pkt_i,
	input  logic                  decode_ready_i,
	input  logic                  flush_i,
	output fetch_pkg::fetch_pkt_t head_pkt_o,
	output logic                  pop_o,
	output logic                  almost_full_o
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;
	// One extra bit so a full queue is distinct from empty
	typedef logic [PTR_W:0] cnt_t;

	// ======================================================================
	// Storage and pointers
	// ======================================================================

	fetch_pkg::fetch_pkt_t mem_q [QUEUE_DEPTH];
	ptr_t rd_ptr_q;
	ptr_t wr_ptr_q;
	cnt_t count_q;
	logic empty;

	assign empty = (count_q == '0);

	// Pop whenever decode takes a non-empty head
	assign pop_o = ~empty & decode_ready_i;

	// Leaves room for the one block still in flight
	assign almost_full_o = (count_q >= cnt_t'(QUEUE_DEPTH - 1));

	// Head with valid bits hidden unless popped
	always_comb begin
		head_pkt_o = mem_q[rd_ptr_q];
		if (!pop_o) begin
			head_pkt_o.valid = '0;
		end
	end

	// ======================================================================
	// Pointer and count update
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end else if (flush_i) begin
			// Drop everything behind a redirect
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + ptr_t'(1);
			end
			if (pop_o) begin
				rd_ptr_q <= rd_ptr_q + ptr_t'(1);
			end
			case ({push_i, pop_o})
				2'b10:   count_q <= count_q + cnt_t'(1);
				2'b01:   count_q <= count_q - cnt_t'(1);
				default: count_q <= count_q;
			endcase
		end
	end

	// Entry write
	always_ff @(posedge clk) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= push_pkt_i;
		end
	end

endmodule

/* hw/pre_checker.sv */
module pre_checker (
	input  fetch_pkg::fetch_pkt_t             head_pkt_i,
	output logic                              redirect_valid_o,
	output fetch_pkg::redirect_t              redirect_o,
	output logic [fetch_pkg::FETCH_WIDTH-1:0] slot_valid_o
);

	// ======================================================================
	// Miss detection per slot
	// ======================================================================

	fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] slot_pc;
	logic [fetch_pkg::FETCH_WIDTH-1:0] miss;

	always_comb begin
		for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
			// Slot address from block base and slot number
			slot_pc[i] = {head_pkt_i.pc[31:3], i[0], 2'b00};
			// Predicted taken here, yet the word is no branch
			miss[i] = head_pkt_i.valid[i] &&
				head_pkt_i.br_info.taken &&
				(head_pkt_i.br_info.br_idx == slot_pc[i][2]) &&
				(head_pkt_i.br_type[i] == fetch_pkg::BR_NONE);
		end
	end

	// ======================================================================
	// Redirect and younger slot kill
	// ======================================================================

	always_comb begin
		redirect_valid_o = |miss;
		redirect_o.pc = '0;
		redirect_o.target = '0;
		redirect_o.ras_ptr = '0;
		redirect_o.lpht_idx = '0;

		// At most one slot matches br_idx
		for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
			if (miss[i]) begin
				redirect_o.pc = slot_pc[i];
				// Resume right after the bad slot
				redirect_o.target = slot_pc[i] + 32'd4;
				redirect_o.ras_ptr = head_pkt_i.br_info.ras_ptr;
				redirect_o.lpht_idx = slot_pc[i][fetch_pkg::LPHT_ADDR_WIDTH+1:2];
			end
		end

		// Slot itself stays, anything younger goes
		slot_valid_o = head_pkt_i.valid;
		for (int i = 1; i < fetch_pkg::FETCH_WIDTH; i++) begin
			slot_valid_o[i] = head_pkt_i.valid[i] & ~miss[i-1];
		end
	end

endmodule

/* hw/fetch_frontend.sv */
module fetch_frontend #(
	parameter int               QUEUE_DEPTH = 4,
	parameter fetch_pkg::addr_t RESET_PC    = 32'h0000_1000
) (
	input  logic                                           clk,
	input  logic                                           rst_n_i,
	input  fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0]  inst_i,
	input  logic                                           decode_ready_i,
	input  logic                                           upd_valid_i,
	input  fetch_pkg::addr_t                               upd_pc_i,
	input  fetch_pkg::addr_t                               upd_target_i,
	input  fetch_pkg::br_type_e                            upd_type_i,
	output logic                                           fetch_req_o,
	output fetch_pkg::addr_t                               fetch_pc_o,
	output logic [fetch_pkg::FETCH_WIDTH-1:0]              dec_valid_o,
	output fetch_pkg::addr_t                               dec_pc_o,
	output fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0]  dec_inst_o,
	output logic                                           redirect_valid_o,
	output fetch_pkg::addr_t                               redirect_pc_o,
	output fetch_pkg::addr_t                               redirect_target_o
);

	// ======================================================================
	// Internal nets
	// ======================================================================

	logic                                              almost_full;
	logic                                              push;
	logic                                              pop;
	logic [fetch_pkg::FETCH_WIDTH-1:0]                 inflight_slot_valid;
	fetch_pkg::br_info_t                               inflight_info;
	fetch_pkg::addr_t                                  inflight_pc;
	fetch_pkg::br_type_e [fetch_pkg::FETCH_WIDTH-1:0]  br_type;
	fetch_pkg::fetch_pkt_t                             push_pkt;
	fetch_pkg::fetch_pkt_t                             head_pkt;
	fetch_pkg::redirect_t                              redirect;

	// Queue entry from in-flight request plus returned words
	assign push_pkt.pc = inflight_pc;
	assign push_pkt.valid = inflight_slot_valid;
	assign push_pkt.inst = inst_i;
	assign push_pkt.br_type = br_type;
	assign push_pkt.br_info = inflight_info;

	branch_predictor #(
		.RESET_PC (RESET_PC)
	) u_branch_predictor (
		.clk                   (clk),
		.rst_n_i               (rst_n_i),
		.almost_full_i         (almost_full),
		.redirect_valid_i      (redirect_valid_o),
		.redirect_i            (redirect),
		.upd_valid_i           (upd_valid_i),
		.upd_pc_i              (upd_pc_i),
		.upd_target_i          (upd_target_i),
		.upd_type_i            (upd_type_i),
		.fetch_req_o           (fetch_req_o),
		.fetch_pc_o            (fetch_pc_o),
		.inflight_valid_o      (push),
		.inflight_slot_valid_o (inflight_slot_valid),
		.inflight_info_o       (inflight_info),
		.inflight_pc_o         (inflight_pc)
	);

	pre_decoder u_pre_decoder (
		.inst_i    (inst_i),
		.br_type_o (br_type)
	);

	fetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_fetch_queue (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.push_i         (push),
		.push_pkt_i     (push_pkt),
		.decode_ready_i (decode_ready_i),
		.flush_i        (redirect_valid_o),
		.head_pkt_o     (head_pkt),
		.pop_o          (pop),
		.almost_full_o  (almost_full)
	);

	pre_checker u_pre_checker (
		.head_pkt_i       (head_pkt),
		.redirect_valid_o (redirect_valid_o),
		.redirect_o       (redirect),
		.slot_valid_o     (dec_valid_o)
	);

	// Decode view of the popped head
	assign dec_pc_o = pop ? head_pkt.pc : '0;
	assign dec_inst_o = head_pkt.inst;
	assign redirect_pc_o = redirect.pc;
	assign redirect_target_o = redirect.target;

endmodule

/* verif/fetch_frontend_assert.sv */
module fetch_frontend_assert (
	input logic                              clk,
	input logic                              rst_n_i,
	input logic                              upd_valid_i,
	input logic                              fetch_req_i,
	input fetch_pkg::addr_t                  fetch_pc_i,
	input logic [fetch_pkg::FETCH_WIDTH-1:0] dec_valid_i,
	input fetch_pkg::addr_t                  dec_pc_i,
	input logic                              redirect_valid_i,
	input fetch_pkg::addr_t                  redirect_pc_i,
	input fetch_pkg::addr_t                  redirect_target_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// Set once reset has been seen at a clock edge
	logic in_reset_q = 1'b0;

	// Training seen so far, and the last decoded block
	logic             trained_q;
	logic             seen_blk_q;
	fetch_pkg::addr_t last_pc_q;

	always_ff @(posedge clk) begin
		in_reset_q <= ~rst_n_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			trained_q <= 1'b0;
			seen_blk_q <= 1'b0;
			last_pc_q <= '0;
		end else begin
			if (upd_valid_i) begin
				trained_q <= 1'b1;
			end
			if (dec_valid_i != '0) begin
				seen_blk_q <= 1'b1;
				last_pc_q <= dec_pc_i;
			end
		end
	end

	// ======================================================================
	// Reset behaviour
	// ======================================================================

	a_reset_quiet: assert property (@(posedge clk)
		(in_reset_q && !rst_n_i) |-> (!fetch_req_i && dec_valid_i == '0 && !redirect_valid_i))
		else $error("fetch request, decode or redirect active during reset");

	// ======================================================================
	// Sequential fetch with an empty table
	// ======================================================================

	// Blocks step by 8 until the first training
	a_seq_dec_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
		(!trained_q && seen_blk_q && dec_valid_i != '0) |->
			(dec_pc_i == last_pc_q + 32'd8))
		else $error("decode block is not the previous one plus 8 before training");

	// Nothing predicted, nothing to redirect
	a_seq_no_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
		!trained_q |-> !redirect_valid_i)
		else $error("redirect raised before any training");

	// ======================================================================
	// Redirect behaviour
	// ======================================================================

	// Target is the bad slot plus one word
	a_redirect_target: assert property (@(posedge clk) disable iff (!rst_n_i)
		redirect_valid_i |-> (redirect_target_i == redirect_pc_i + 32'd4))
		else $error("redirect target is not redirect pc plus 4");

	// Fetch restarts at the target block
	a_redirect_fetch_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
		$past(redirect_valid_i) |-> (fetch_pc_i == ($past(redirect_target_i) & ~32'h7)))
		else $error("fetch pc after redirect is not the target block");

	// Slot 1 dies behind a bad slot 0
	a_slot1_killed: assert property (@(posedge clk) disable iff (!rst_n_i)
		(redirect_valid_i && !redirect_pc_i[2]) |-> !dec_valid_i[1])
		else $error("younger slot still valid behind a slot 0 redirect");

	// Queue flushed, nothing decodes for two cycles
	a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
		($past(redirect_valid_i) || $past(redirect_valid_i, 2)) |-> (dec_valid_i == '0))
		else $error("decode output right after a redirect flush");

endmodule

/* verif/fetch_frontend_tb.sv */
module fetch_frontend_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_PHASES = 5;
	localparam int PHASE_MAX_CYCLES = 400;
	// Five phases at most 400 cycles each
	localparam int WATCHDOG_CYCLES = NUM_PHASES * PHASE_MAX_CYCLES;
	localparam int QUEUE_DEPTH = 4;
	localparam fetch_pkg::addr_t RESET_PC = 32'h0000_1000;

	// Expected decode block, formed at request time
	typedef struct packed {
		fetch_pkg::addr_t pc;
		logic [1:0]       valid;
		logic             taken;
		logic             slot;
		fetch_pkg::addr_t npc;
	} exp_blk_t;

	logic                                          clk;
	logic                                          rst_n_i;
	fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0] inst_i;
	logic                                          decode_ready_i;
	logic                                          upd_valid_i;
	fetch_pkg::addr_t                              upd_pc_i;
	fetch_pkg::addr_t                              upd_target_i;
	fetch_pkg::br_type_e                           upd_type_i;
	logic                                          fetch_req_o;
	fetch_pkg::addr_t                              fetch_pc_o;
	logic [fetch_pkg::FETCH_WIDTH-1:0]             dec_valid_o;
	fetch_pkg::addr_t                              dec_pc_o;
	fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0] dec_inst_o;
	logic                                          redirect_valid_o;
	fetch_pkg::addr_t                              redirect_pc_o;
	fetch_pkg::addr_t                              redirect_target_o;

	// Reference table and fetch path
	fetch_pkg::addr_t m_pc;
	logic [15:0]      m_valid;
	fetch_pkg::addr_t m_tab_pc [16];
	fetch_pkg::addr_t m_tab_tgt [16];
	exp_blk_t         exp_q [$];

	int value_errors;
	int other_errors;
	int req_count;
	int blk_count;
	int redirect_count;
	integer seed;

	fetch_frontend #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.RESET_PC    (RESET_PC)
	) UUT (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.inst_i            (inst_i),
		.decode_ready_i    (decode_ready_i),
		.upd_valid_i       (upd_valid_i),
		.upd_pc_i          (upd_pc_i),
		.upd_target_i      (upd_target_i),
		.upd_type_i        (upd_type_i),
		.fetch_req_o       (fetch_req_o),
		.fetch_pc_o        (fetch_pc_o),
		.dec_valid_o       (dec_valid_o),
		.dec_pc_o          (dec_pc_o),
		.dec_inst_o        (dec_inst_o),
		.redirect_valid_o  (redirect_valid_o),
		.redirect_pc_o     (redirect_pc_o),
		.redirect_target_o (redirect_target_o)
	);

	bind fetch_frontend fetch_frontend_assert u_fetch_frontend_assert (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.upd_valid_i       (upd_valid_i),
		.fetch_req_i       (fetch_req_o),
		.fetch_pc_i        (fetch_pc_o),
		.dec_valid_i       (dec_valid_o),
		.dec_pc_i          (dec_pc_o),
		.redirect_valid_i  (redirect_valid_o),
		.redirect_pc_i     (redirect_pc_o),
		.redirect_target_i (redirect_target_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ======================================================================
	// Memory contents and reference prediction
	// ======================================================================

	// Conditional branch at offsets 0x18 and 0x1c of each 64 bytes
	function automatic logic is_branch_addr(input fetch_pkg::addr_t addr);
		return addr[5:3] == 3'd3;
	endfunction

	// Plain addi word carries address bits as immediate
	function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t addr);
		if (is_branch_addr(addr)) begin
			return 32'h0000_0063;
		end
		return {addr[13:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
	endfunction

	function automatic exp_blk_t predict(input fetch_pkg::addr_t pc);
		exp_blk_t e;
		fetch_pkg::addr_t a;
		logic en0;
		e.pc = {pc[31:3], 3'b000};
		en0 = ~pc[2];
		e.valid = {1'b1, en0};
		e.taken = 1'b0;
		e.slot = 1'b0;
		e.npc = e.pc + 32'd8;
		// Downward walk so slot 0 wins
		for (int s = 1; s >= 0; s--) begin
			a = e.pc | (32'(s) << 2);
			if ((s == 1 || en0) && m_valid[a[5:2]] && m_tab_pc[a[5:2]][31:6] == a[31:6]) begin
				e.taken = 1'b1;
				e.slot = s[0];
				e.npc = m_tab_tgt[a[5:2]];
			end
		end
		if (e.taken && !e.slot) begin
			e.valid[1] = 1'b0;
		end
		return e;
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("FAIL %s expected %h actual %h", name, exp_v, act_v);
		value_errors++;
	endtask

	task automatic report_other(input string msg);
		$display("ERROR %s", msg);
		other_errors++;
	endtask

	task automatic train_entry(input fetch_pkg::addr_t pc, input fetch_pkg::addr_t target,
		input fetch_pkg::br_type_e kind);
		upd_valid_i <= 1'b1;
		upd_pc_i <= pc;
		upd_target_i <= target;
		upd_type_i <= kind;
		@(posedge clk);
		upd_valid_i <= 1'b0;
	endtask

	// Memory answers one cycle after each request
	always @(posedge clk) begin
		if (fetch_req_o) begin
			inst_i[0] <= mem_word(fetch_pc_o);
			inst_i[1] <= mem_word(fetch_pc_o + 32'd4);
		end
	end

	// ======================================================================
	// Monitor and reference model
	// ======================================================================

	always @(posedge clk) begin
		exp_blk_t e;
		fetch_pkg::addr_t slot_pc;
		logic miss;
		if (rst_n_i) begin
			// Redirects as the DUT raises them
			if (redirect_valid_o) begin
				redirect_count++;
			end
			// Request uses the table as it was before this edge
			if (fetch_req_o) begin
				if (fetch_pc_o != {m_pc[31:3], 3'b000}) begin
					report_value("fetch_pc", {m_pc[31:3], 3'b000}, fetch_pc_o);
				end
				e = predict(m_pc);
				exp_q.push_back(e);
				m_pc = e.npc;
				req_count++;
			end
			if (upd_valid_i) begin
				m_valid[upd_pc_i[5:2]] = 1'b1;
				m_tab_pc[upd_pc_i[5:2]] = upd_pc_i;
				m_tab_tgt[upd_pc_i[5:2]] = upd_target_i;
			end
			if (dec_valid_o != '0) begin
				blk_count++;
				if (blk_count > req_count) begin
					report_other("more decode blocks than fetch requests");
				end
				if (exp_q.size() == 0) begin
					report_other("decode block with no request outstanding");
				end else begin
					e = exp_q.pop_front();
					slot_pc = e.pc | {29'd0, e.slot, 2'b00};
					miss = e.taken && !is_branch_addr(slot_pc);
					if (dec_pc_o != e.pc) begin
						report_value("dec_pc", e.pc, dec_pc_o);
					end
					if (dec_valid_o != e.valid) begin
						report_value("dec_valid", 32'(e.valid), 32'(dec_valid_o));
					end
					for (int i = 0; i < 2; i++) begin
						if (e.valid[i] && dec_inst_o[i] != mem_word(e.pc + 32'(4 * i))) begin
							report_value("dec_inst", mem_word(e.pc + 32'(4 * i)), dec_inst_o[i]);
						end
					end
					if (redirect_valid_o != miss) begin
						report_value("redirect_valid", 32'(miss), 32'(redirect_valid_o));
					end
					if (miss) begin
						if (redirect_pc_o != slot_pc) begin
							report_value("redirect_pc", slot_pc, redirect_pc_o);
						end
						// Flush, restart after the slot, drop the entry
						exp_q.delete();
						m_pc = slot_pc + 32'd4;
						m_valid[slot_pc[5:2]] = 1'b0;
					end
				end
			end else if (redirect_valid_o) begin
				report_other("redirect without a decoded block");
			end
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial begin
		fetch_pkg::addr_t loop_base;
		logic [31:0] rnd;
		int phase1_redirects;
		clk = 1'b0;
		rst_n_i = 1'b0;
		inst_i = '0;
		decode_ready_i = 1'b1;
		upd_valid_i = 1'b0;
		upd_pc_i = '0;
		upd_target_i = '0;
		upd_type_i = fetch_pkg::BR_NONE;
		m_pc = RESET_PC;
		m_valid = '0;
		value_errors = 0;
		other_errors = 0;
		req_count = 0;
		blk_count = 0;
		redirect_count = 0;
		seed = 32'hbe8f413b;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n_i <= 1'b1;

		// Plain sequential fetch
		repeat (100) @(posedge clk);
		phase1_redirects = redirect_count;
		if (phase1_redirects != 0) begin
			report_value("phase1_redirects", 32'd0, 32'(phase1_redirects));
		end

		// True backward branch ahead of the fetch PC forms a loop
		loop_base = (fetch_pc_o + 32'd128) & ~32'h3f;
		train_entry(loop_base + 32'h18, loop_base, fetch_pkg::BR_BRANCH);
		repeat (150) @(posedge clk);

		// False entries on plain words, slot 0 then slot 1
		train_entry(loop_base + 32'h08, loop_base + 32'h20, fetch_pkg::BR_CALL);
		repeat (150) @(posedge clk);
		train_entry(loop_base + 32'h14, loop_base + 32'h28, fetch_pkg::BR_RET);
		repeat (150) @(posedge clk);

		// Random decode stalls
		repeat (300) begin
			@(posedge clk);
			rnd = $random(seed);
			decode_ready_i <= rnd[0];
		end
		@(posedge clk);
		decode_ready_i <= 1'b1;

		// Training held so it meets the redirect of the same slot
		upd_valid_i <= 1'b1;
		upd_pc_i <= loop_base + 32'h10;
		upd_target_i <= loop_base + 32'h30;
		upd_type_i <= fetch_pkg::BR_BRANCH;
		repeat (150) @(posedge clk);
		upd_valid_i <= 1'b0;
		repeat (50) @(posedge clk);

		if (redirect_count < 3) begin
			report_other("fewer redirects than the false entries call for");
		end
		$display("Errors: %0d value, %0d other; blocks %0d, requests %0d, redirects %0d",
			value_errors, other_errors, blk_count, req_count, redirect_count);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the stimulus finished");
		$display("Test failed");
		$finish;
	end

endmodule

/* filelist.f */
hw/fetch_pkg.sv
hw/branch_predictor.sv
hw/pre_decoder.sv
hw/fetch_queue.sv
hw/pre_checker.sv
hw/fetch_frontend.sv
verif/fetch_frontend_assert.sv
verif/fetch_frontend_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_fetch_frontend

verilator --binary --timing --assert -Wno-fatal \
	--top-module fetch_frontend_tb \
	-f filelist.f \
	-o "$BIN"
if [ $? -ne 0 ]; then
	echo "Compilation failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
	exit 0
fi
exit 1
